// File: nkmd_defines.svh
`ifndef NKMD_DEFINES_SVH
`define NKMD_DEFINES_SVH

// Scratchpad page in address bits 15 to 12
`define NKMD_SPAD_PAGE      4'h1

// DMA control registers
`define NKMD_REG_DRAM_ADDR  16'hc100
`define NKMD_REG_SPAD_ADDR  16'hc101
`define NKMD_REG_BURST_LEN  16'hc102
`define NKMD_REG_DMA_CTRL   16'hc103

// Memory controller command codes
`define NKMD_MIG_INSTR_WR   3'b010
`define NKMD_MIG_INSTR_RD   3'b011

`define NKMD_SPAD_DEPTH     1024

`endif

// File: nkmd_pkg.sv
package nkmd_pkg;

    typedef logic [31:0] word_t;           // Bus and memory data word
    typedef logic [15:0] bus_addr_t;
    typedef logic [9:0]  spad_addr_t;      // Scratchpad word index
    typedef logic [24:0] dram_word_addr_t; // Byte address bits 26 to 2
    typedef logic [5:0]  burst_len_t;      // Burst length minus one
    typedef logic [2:0]  mig_instr_t;
    typedef logic [6:0]  mig_count_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL_WRBUF,
        EMIT_WR_CMD,
        EMIT_RD_CMD,
        WAIT_RD_DATA
    } dma_state_e;

    // Command port of the memory controller
    typedef struct packed {
        logic        en;
        mig_instr_t  instr;
        burst_len_t  bl;
        logic [29:0] byte_addr;
    } mig_cmd_t;

    typedef struct packed {
        logic  en;
        word_t data;
    } mig_wr_t;

    typedef struct packed {
        word_t      data;                  // Head of the read FIFO
        mig_count_t count;
    } mig_rd_t;

endpackage

// File: nkmd_spad.sv
`timescale 1ns/1ps
`include "nkmd_defines.svh"

module nkmd_spad
    import nkmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       cpu_we_i,
    input  spad_addr_t cpu_addr_i,
    input  word_t      cpu_wdata_i,
    output word_t      cpu_rdata_o,

    input  spad_addr_t dma_rd_addr_i,
    output word_t      dma_rdata_o,

    input  logic       dma_we_i,
    input  spad_addr_t dma_waddr_i,
    input  word_t      dma_wdata_i
);

    word_t mem [`NKMD_SPAD_DEPTH];
    word_t dma_rdata_ff;

    always_ff @(posedge clk) begin
        if (cpu_we_i) begin
            mem[cpu_addr_i] <= cpu_wdata_i;
        end
        // Later assignment wins, so DMA has priority on an index collision
        if (dma_we_i) begin
            mem[dma_waddr_i] <= dma_wdata_i;
        end
    end

    // Registered DMA read feeds the write stream one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            dma_rdata_ff <= '0;
        end else begin
            dma_rdata_ff <= mem[dma_rd_addr_i];
        end
    end

    assign cpu_rdata_o = mem[cpu_addr_i]; // Async, registered in the bus mux
    assign dma_rdata_o = dma_rdata_ff;

endmodule

// File: nkmd_dma_regs.sv
`timescale 1ns/1ps
`include "nkmd_defines.svh"

module nkmd_dma_regs
    import nkmd_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  bus_addr_t       addr_i,
    input  word_t           data_i,
    input  logic            we_i,
    output word_t           data_o,

    output logic            spad_we_o,
    output spad_addr_t      spad_addr_o,
    output word_t           spad_wdata_o,
    input  word_t           spad_rdata_i,

    output dram_word_addr_t dram_addr_o,
    output burst_len_t      burst_len_o,

    output logic            spad_ptr_wr_o,
    output spad_addr_t      spad_ptr_o,
    input  spad_addr_t      spad_ptr_i,

    output logic            start_o,
    output logic            start_to_dram_o,

    input  logic            idle_i
);

    logic            sel_spad;
    logic            sel_dram_addr;
    logic            sel_spad_addr;
    logic            sel_burst_len;
    logic            sel_ctrl;
    dram_word_addr_t dram_addr_ff;
    burst_len_t      burst_len_ff;
    word_t           rdata_nxt;
    word_t           rdata_ff;

    assign sel_spad      = (addr_i[15:12] == `NKMD_SPAD_PAGE);
    assign sel_dram_addr = (addr_i == `NKMD_REG_DRAM_ADDR);
    assign sel_spad_addr = (addr_i == `NKMD_REG_SPAD_ADDR);
    assign sel_burst_len = (addr_i == `NKMD_REG_BURST_LEN);
    assign sel_ctrl      = (addr_i == `NKMD_REG_DMA_CTRL);

    assign spad_we_o    = we_i && sel_spad;
    assign spad_addr_o  = addr_i[9:0];
    assign spad_wdata_o = data_i;

    // Pointer lives in the engine, only the load is forwarded
    assign spad_ptr_wr_o   = we_i && sel_spad_addr;
    assign spad_ptr_o      = data_i[9:0];
    assign start_o         = we_i && sel_ctrl && idle_i; // Ignored while busy
    assign start_to_dram_o = data_i[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            dram_addr_ff <= '0;
            burst_len_ff <= '0;
            rdata_ff     <= '0;
        end else begin
            if (we_i && sel_dram_addr) begin
                dram_addr_ff <= data_i[26:2]; // Word aligned
            end
            if (we_i && sel_burst_len) begin
                burst_len_ff <= data_i[5:0];
            end
            rdata_ff <= rdata_nxt; // Pre-write contents on a write
        end
    end

    always_comb begin
        rdata_nxt = '0;
        if (sel_spad) begin
            rdata_nxt = spad_rdata_i;
        end else if (sel_dram_addr) begin
            rdata_nxt = {5'b0, dram_addr_ff, 2'b00};
        end else if (sel_spad_addr) begin
            rdata_nxt = {22'b0, spad_ptr_i};
        end else if (sel_burst_len) begin
            rdata_nxt = {26'b0, burst_len_ff};
        end else if (sel_ctrl) begin
            rdata_nxt = {31'b0, idle_i};
        end
    end

    assign data_o      = rdata_ff;
    assign dram_addr_o = dram_addr_ff;
    assign burst_len_o = burst_len_ff;

endmodule

// File: nkmd_dma_engine.sv
`timescale 1ns/1ps
`include "nkmd_defines.svh"

module nkmd_dma_engine
    import nkmd_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            start_i,
    input  logic            start_to_dram_i,

    input  logic            spad_ptr_wr_i,
    input  spad_addr_t      spad_ptr_i,
    output spad_addr_t      spad_ptr_o,
    output logic            idle_o,

    input  dram_word_addr_t dram_addr_i,
    input  burst_len_t      burst_len_i,

    output spad_addr_t      spad_rd_addr_o,
    input  word_t           spad_rdata_i,

    output logic            spad_we_o,
    output spad_addr_t      spad_waddr_o,
    output word_t           spad_wdata_o,

    output mig_cmd_t        mig_cmd_o,
    output mig_wr_t         mig_wr_o,
    output logic            mig_rd_en_o,
    input  mig_rd_t         mig_rd_i
);

    dma_state_e state_ff;
    burst_len_t burst_left_ff;
    spad_addr_t ptr_ff;
    logic       rd_avail;

    assign rd_avail = (mig_rd_i.count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_ff      <= IDLE;
            burst_left_ff <= '0;
            ptr_ff        <= '0;
        end else begin
            if (spad_ptr_wr_i) begin
                ptr_ff <= spad_ptr_i; // Engine updates below take priority
            end
            case (state_ff)
                IDLE: begin
                    burst_left_ff <= burst_len_i;
                    if (start_i) begin
                        if (start_to_dram_i) begin
                            // First word is already on its way out of the registered read
                            ptr_ff   <= ptr_ff + 10'd1;
                            state_ff <= FILL_WRBUF;
                        end else begin
                            state_ff <= EMIT_RD_CMD;
                        end
                    end
                end
                FILL_WRBUF: begin
                    if (burst_left_ff != '0) begin
                        ptr_ff        <= ptr_ff + 10'd1;
                        burst_left_ff <= burst_left_ff - 6'd1;
                    end else begin
                        state_ff <= EMIT_WR_CMD;
                    end
                end
                EMIT_WR_CMD: begin
                    state_ff <= IDLE;
                end
                EMIT_RD_CMD: begin
                    state_ff <= WAIT_RD_DATA;
                end
                WAIT_RD_DATA: begin
                    if (rd_avail) begin
                        if (burst_left_ff != '0) begin
                            ptr_ff        <= ptr_ff + 10'd1;
                            burst_left_ff <= burst_left_ff - 6'd1;
                        end else begin
                            state_ff <= IDLE; // Pointer stays on the last word
                        end
                    end
                end
                default: begin
                    state_ff <= IDLE;
                end
            endcase
        end
    end

    assign idle_o         = (state_ff == IDLE);
    assign spad_ptr_o     = ptr_ff;
    assign spad_rd_addr_o = ptr_ff;

    // Read returns go straight into the scratchpad
    assign spad_we_o    = (state_ff == WAIT_RD_DATA) && rd_avail;
    assign spad_waddr_o = ptr_ff;
    assign spad_wdata_o = mig_rd_i.data;

    assign mig_cmd_o.en        = (state_ff == EMIT_WR_CMD) || (state_ff == EMIT_RD_CMD);
    assign mig_cmd_o.instr     = (state_ff == EMIT_RD_CMD) ? `NKMD_MIG_INSTR_RD
                                                           : `NKMD_MIG_INSTR_WR;
    assign mig_cmd_o.bl        = burst_len_i;
    assign mig_cmd_o.byte_addr = {3'b000, dram_addr_i, 2'b00};

    assign mig_wr_o.en   = (state_ff == FILL_WRBUF);
    assign mig_wr_o.data = spad_rdata_i;

    assign mig_rd_en_o = (state_ff == WAIT_RD_DATA); // Model pops only when count is nonzero

endmodule

// File: nkmd_ddr3_mig_if.sv
`timescale 1ns/1ps

module nkmd_ddr3_mig_if
    import nkmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  bus_addr_t addr_i,
    input  word_t     data_i,
    input  logic      we_i,
    output word_t     data_o,

    output mig_cmd_t  mig_cmd_o,
    output mig_wr_t   mig_wr_o,
    output logic      mig_rd_en_o,
    input  mig_rd_t   mig_rd_i
);

    logic            cpu_spad_we;
    spad_addr_t      cpu_spad_addr;
    word_t           cpu_spad_wdata;
    word_t           cpu_spad_rdata;

    dram_word_addr_t dram_addr;
    burst_len_t      burst_len;
    logic            spad_ptr_wr;
    spad_addr_t      spad_ptr_load;
    spad_addr_t      spad_ptr;
    logic            start;
    logic            start_to_dram;
    logic            idle;

    spad_addr_t      dma_rd_addr;
    word_t           dma_rdata;
    logic            dma_we;
    spad_addr_t      dma_waddr;
    word_t           dma_wdata;

    nkmd_dma_regs regs_i (
        .clk             (clk),
        .rst             (rst),
        .addr_i          (addr_i),
        .data_i          (data_i),
        .we_i            (we_i),
        .data_o          (data_o),
        .spad_we_o       (cpu_spad_we),
        .spad_addr_o     (cpu_spad_addr),
        .spad_wdata_o    (cpu_spad_wdata),
        .spad_rdata_i    (cpu_spad_rdata),
        .dram_addr_o     (dram_addr),
        .burst_len_o     (burst_len),
        .spad_ptr_wr_o   (spad_ptr_wr),
        .spad_ptr_o      (spad_ptr_load),
        .spad_ptr_i      (spad_ptr),
        .start_o         (start),
        .start_to_dram_o (start_to_dram),
        .idle_i          (idle)
    );

    nkmd_spad spad_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_we_i      (cpu_spad_we),
        .cpu_addr_i    (cpu_spad_addr),
        .cpu_wdata_i   (cpu_spad_wdata),
        .cpu_rdata_o   (cpu_spad_rdata),
        .dma_rd_addr_i (dma_rd_addr),
        .dma_rdata_o   (dma_rdata),
        .dma_we_i      (dma_we),
        .dma_waddr_i   (dma_waddr),
        .dma_wdata_i   (dma_wdata)
    );

    nkmd_dma_engine engine_i (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start),
        .start_to_dram_i (start_to_dram),
        .spad_ptr_wr_i   (spad_ptr_wr),
        .spad_ptr_i      (spad_ptr_load),
        .spad_ptr_o      (spad_ptr),
        .idle_o          (idle),
        .dram_addr_i     (dram_addr),
        .burst_len_i     (burst_len),
        .spad_rd_addr_o  (dma_rd_addr),
        .spad_rdata_i    (dma_rdata),
        .spad_we_o       (dma_we),
        .spad_waddr_o    (dma_waddr),
        .spad_wdata_o    (dma_wdata),
        .mig_cmd_o       (mig_cmd_o),
        .mig_wr_o        (mig_wr_o),
        .mig_rd_en_o     (mig_rd_en_o),
        .mig_rd_i        (mig_rd_i)
    );

endmodule

// File: mig_port_model.sv
`timescale 1ns/1ps
`include "nkmd_defines.svh"

module mig_port_model
    import nkmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mig_cmd_t cmd_i,
    input  mig_wr_t  wr_i,
    input  logic     rd_en_i,
    output mig_rd_t  rd_o
);

    word_t       dram [4096];                 // Keyed by byte address bits 13 to 2
    word_t       wr_buf [64];
    word_t       rd_fifo [128];
    logic [5:0]  wr_cnt;
    logic [6:0]  rd_head;
    logic [6:0]  rd_tail;
    logic [11:0] pend_addr;
    logic [6:0]  pend_left;
    logic [3:0]  rd_delay;
    logic        gap_ff;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4096; i++) begin
                dram[12'(i)] = 32'hd0a0_0000 | word_t'(i);
            end
            wr_cnt    <= '0;
            rd_head   <= '0;
            rd_tail   <= '0;
            pend_addr <= '0;
            pend_left <= '0;
            rd_delay  <= '0;
            gap_ff    <= 1'b0;
        end else begin
            if (wr_i.en) begin
                wr_buf[wr_cnt] <= wr_i.data;
                wr_cnt         <= wr_cnt + 6'd1;
            end
            if (cmd_i.en && cmd_i.instr == `NKMD_MIG_INSTR_WR) begin
                // Write command drains the buffered burst into the array
                for (int i = 0; i <= int'(cmd_i.bl); i++) begin
                    dram[cmd_i.byte_addr[13:2] + 12'(i)] = wr_buf[6'(i)];
                end
                wr_cnt <= '0;
            end else if (cmd_i.en && cmd_i.instr == `NKMD_MIG_INSTR_RD) begin
                pend_addr <= cmd_i.byte_addr[13:2];
                pend_left <= 7'(cmd_i.bl) + 7'd1;
                rd_delay  <= 4'(2 + $urandom % 7); // 2 to 8 cycles
            end else if (pend_left != '0) begin
                if (rd_delay != '0) begin
                    rd_delay <= rd_delay - 4'd1;
                end else if (!gap_ff && ($urandom % 4) == 0) begin
                    gap_ff <= 1'b1;               // One idle cycle in the stream
                end else begin
                    rd_fifo[rd_tail] <= dram[pend_addr];
                    rd_tail          <= rd_tail + 7'd1;
                    pend_addr        <= pend_addr + 12'd1;
                    pend_left        <= pend_left - 7'd1;
                    gap_ff           <= 1'b0;
                end
            end
            if (rd_en_i && rd_o.count != '0) begin
                rd_head <= rd_head + 7'd1;
            end
        end
    end

    assign rd_o.data  = rd_fifo[rd_head];
    assign rd_o.count = rd_tail - rd_head;

endmodule

// File: nkmd_ddr3_mig_if_assert.sv
`timescale 1ns/1ps

module nkmd_ddr3_mig_if_assert
    import nkmd_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input mig_cmd_t cmd_i,
    input mig_wr_t  wr_i,
    input logic     rd_en_i
);

    int fail_cnt = 0;

    cmd_single_pulse: assert property (@(posedge clk) disable iff (rst)
        cmd_i.en |=> !cmd_i.en)
        else begin
            $error("cmd.en held high for more than one cycle");
            fail_cnt++;
        end

    wr_rd_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(wr_i.en && rd_en_i))
        else begin
            $error("wr.en and rd_en high in the same cycle");
            fail_cnt++;
        end

    wr_not_with_cmd: assert property (@(posedge clk) disable iff (rst)
        $rose(wr_i.en) |-> !cmd_i.en)
        else begin
            $error("wr.en rose while cmd.en was high");
            fail_cnt++;
        end

endmodule

// File: tb_nkmd_ddr3_mig_if.sv
`timescale 1ns/1ps
`include "nkmd_defines.svh"

module tb_nkmd_ddr3_mig_if
    import nkmd_pkg::*;
();

    // Three bursts of up to 64 words at about 2 cycles per word, plus bus traffic, with margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk;
    logic      rst;
    bus_addr_t addr;
    word_t     wdata;
    logic      we;
    word_t     rdata;
    mig_cmd_t  mig_cmd;
    mig_wr_t   mig_wr;
    logic      mig_rd_en;
    mig_rd_t   mig_rd;
    int        errors;
    int        checks;
    int        test_err_start;
    int        cycle_cnt;
    word_t     spad_img [`NKMD_SPAD_DEPTH];
    word_t     burst_words [64];

    nkmd_ddr3_mig_if nkmd_ddr3_mig_if_i (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (addr),
        .data_i      (wdata),
        .we_i        (we),
        .data_o      (rdata),
        .mig_cmd_o   (mig_cmd),
        .mig_wr_o    (mig_wr),
        .mig_rd_en_o (mig_rd_en),
        .mig_rd_i    (mig_rd)
    );

    mig_port_model model_i (
        .clk     (clk),
        .rst     (rst),
        .cmd_i   (mig_cmd),
        .wr_i    (mig_wr),
        .rd_en_i (mig_rd_en),
        .rd_o    (mig_rd)
    );

    bind nkmd_ddr3_mig_if nkmd_ddr3_mig_if_assert assert_i (
        .clk     (clk),
        .rst     (rst),
        .cmd_i   (mig_cmd_o),
        .wr_i    (mig_wr_o),
        .rd_en_i (mig_rd_en_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected register readback from the value last written
    function automatic word_t ref_reg_read(input bus_addr_t a, input word_t written,
                                           input logic idle);
        case (a)
            `NKMD_REG_DRAM_ADDR: ref_reg_read = written & 32'h07ff_fffc;
            `NKMD_REG_SPAD_ADDR: ref_reg_read = written & 32'h0000_03ff;
            `NKMD_REG_BURST_LEN: ref_reg_read = written & 32'h0000_003f;
            `NKMD_REG_DMA_CTRL:  ref_reg_read = {31'b0, idle};
            default:             ref_reg_read = '0;
        endcase
    endfunction

    function automatic bus_addr_t spad_bus_addr(input spad_addr_t idx);
        spad_bus_addr = {`NKMD_SPAD_PAGE, 2'b00, idx};
    endfunction

    // Bus tasks start and end on a falling edge
    task automatic bus_write(input bus_addr_t a, input word_t d);
        addr  = a;
        wdata = d;
        we    = 1'b1;
        @(negedge clk);
        we    = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output word_t d);
        addr = a;
        we   = 1'b0;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    task automatic reg_readback(input bus_addr_t a, input string name);
        word_t v;
        word_t got;
        v = $urandom;
        bus_write(a, v);
        bus_read(a, got);
        check_word(name, got, ref_reg_read(a, v, 1'b1));
    endtask

    // Cycles counts from the start write to the first status read that returns one
    task automatic poll_dma_status(output int cycles, output logic saw_busy);
        word_t st;
        cycles   = 1;
        saw_busy = 1'b0;
        bus_read(`NKMD_REG_DMA_CTRL, st);
        while (st[0] == 1'b0) begin
            saw_busy = 1'b1;
            cycles++;
            bus_read(`NKMD_REG_DMA_CTRL, st);
        end
    endtask

    task automatic round_trip(input burst_len_t b);
        word_t       v;
        word_t       rnd;
        word_t       dram_byte;
        spad_addr_t  src;
        spad_addr_t  dst;
        logic [11:0] dram_idx;
        int          cycles;
        logic        busy;
        rnd       = $urandom;
        src       = rnd[9:0];
        dst       = src + 10'd512;                 // Never overlaps a 64-word source
        dram_byte = $urandom & 32'h07ff_fffc;
        dram_idx  = dram_byte[13:2];               // Model array index of the burst
        for (int i = 0; i <= int'(b); i++) begin
            burst_words[6'(i)] = $urandom;
            bus_write(spad_bus_addr(src + 10'(i)), burst_words[6'(i)]);
        end
        bus_write(`NKMD_REG_DRAM_ADDR, dram_byte);
        bus_write(`NKMD_REG_BURST_LEN, {26'b0, b});
        bus_write(`NKMD_REG_SPAD_ADDR, {22'b0, src});
        bus_write(`NKMD_REG_DMA_CTRL, 32'h1);
        poll_dma_status(cycles, busy);
        check_bit("wr_busy_seen", busy, 1'b1);
        check_word("wr_latency", word_t'(cycles), word_t'(int'(b) + 3));
        for (int i = 0; i <= int'(b); i++) begin
            check_word("dram_word", model_i.dram[dram_idx + 12'(i)], burst_words[6'(i)]);
        end
        bus_read(`NKMD_REG_SPAD_ADDR, v);
        check_word("ptr_after_wr", v, (word_t'(src) + word_t'(b) + 1) & 32'h3ff);
        bus_write(`NKMD_REG_SPAD_ADDR, {22'b0, dst});
        bus_write(`NKMD_REG_DMA_CTRL, 32'h0);
        poll_dma_status(cycles, busy);
        check_bit("rd_busy_seen", busy, 1'b1);
        bus_read(`NKMD_REG_SPAD_ADDR, v);
        check_word("ptr_after_rd", v, (word_t'(dst) + word_t'(b)) & 32'h3ff);
        for (int i = 0; i <= int'(b); i++) begin
            bus_read(spad_bus_addr(dst + 10'(i)), v);
            check_word("spad_dst", v, burst_words[6'(i)]);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a DMA transfer never completed", cycle_cnt);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        word_t      v;
        word_t      got;
        word_t      rnd;
        spad_addr_t idx_list [16];
        void'($urandom(96));
        rst            = 1'b1;
        addr           = '0;
        wdata          = '0;
        we             = 1'b0;
        errors         = 0;
        checks         = 0;
        test_err_start = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("data_o", rdata, '0);
        check_bit("mig_cmd_en", mig_cmd.en, 1'b0);
        check_bit("mig_wr_en", mig_wr.en, 1'b0);
        check_bit("mig_rd_en", mig_rd_en, 1'b0);

        reg_readback(`NKMD_REG_DRAM_ADDR, "dram_addr");
        reg_readback(`NKMD_REG_SPAD_ADDR, "spad_addr");
        reg_readback(`NKMD_REG_BURST_LEN, "burst_len");
        bus_read(16'h8000, got);
        check_word("unmapped", got, ref_reg_read(16'h8000, 32'hffff_ffff, 1'b1));
        bus_read(`NKMD_REG_DMA_CTRL, got);
        check_word("dma_ctrl", got, ref_reg_read(`NKMD_REG_DMA_CTRL, '0, 1'b1));
        report_test("registers");

        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            v   = $urandom;
            idx_list[4'(i)]         = rnd[9:0];
            spad_img[idx_list[4'(i)]] = v;        // Repeated indices keep the last word
            bus_write(spad_bus_addr(rnd[9:0]), v);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(spad_bus_addr(idx_list[4'(i)]), got);
            check_word("spad_word", got, spad_img[idx_list[4'(i)]]);
        end
        report_test("scratchpad");

        rnd = $urandom;
        round_trip(rnd[5:0]);
        report_test("dma_random_burst");
        round_trip(6'd0);
        report_test("dma_burst_1");
        round_trip(6'd63);
        report_test("dma_burst_64");

        errors += nkmd_ddr3_mig_if_i.assert_i.fail_cnt;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
nkmd_pkg.sv
nkmd_spad.sv
nkmd_dma_regs.sv
nkmd_dma_engine.sv
nkmd_ddr3_mig_if.sv
mig_port_model.sv
nkmd_ddr3_mig_if_assert.sv
tb_nkmd_ddr3_mig_if.sv

// File: Makefile
TOP = tb_nkmd_ddr3_mig_if

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)

# Pass or fail comes from the pass message in the simulation output
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
